// ==== design/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    parameter int xlen = 32;
    parameter int reg_addr_w = 5;

    // major opcodes of rv32imf, bits [6:0] of the instruction.
    typedef enum logic [6:0] {
        op_lui      = 7'b0110111,
        op_auipc    = 7'b0010111,
        op_jal      = 7'b1101111,
        op_jalr     = 7'b1100111,
        op_branch   = 7'b1100011,
        op_load     = 7'b0000011,
        op_store    = 7'b0100011,
        op_imm      = 7'b0010011,
        op_reg      = 7'b0110011,
        op_system   = 7'b1110011,
        op_load_fp  = 7'b0000111,
        op_store_fp = 7'b0100111,
        op_fp       = 7'b1010011,
        op_fmadd    = 7'b1000011,
        op_fmsub    = 7'b1000111,
        op_fnmsub   = 7'b1001011,
        op_fnmadd   = 7'b1001111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_lui_pass,
        alu_mul
    } alu_ctrl_t;

    typedef enum logic [4:0] {
        fadd,
        fsub,
        fmul,
        fdiv,
        fsqrt,
        fsgnj,
        fminmax,
        fcvt_w,
        fcvt_s,
        fmv_x,
        fmv_w,
        fcmp,
        fclass,
        fmadd,
        fmsub,
        fnmsub,
        fnmadd,
        none
    } fpu_ctrl_t;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j,
        imm_none
    } imm_src_t;

    // what the write-back stage stores into rd.
    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc4,
        res_fpu
    } result_src_t;

endpackage

`default_nettype wire

// ==== design/control_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  decode_pkg::opcode_t                 opcode,
    input  logic [2:0]                          funct3,
    input  logic [6:0]                          funct7,
    input  logic [decode_pkg::reg_addr_w-1:0]   rs2,
    output logic                                reg_write,
    output logic                                fpu_reg_write,
    output logic                                mem_write,
    output logic                                mem_read,
    output logic                                branch,
    output logic                                jump,
    output logic                                alu_src,
    output logic                                fp_mem,
    output logic                                csr_write,
    output logic                                illegal,
    output decode_pkg::alu_ctrl_t               alu_ctrl,
    output decode_pkg::fpu_ctrl_t               fpu_ctrl,
    output decode_pkg::imm_src_t                imm_src,
    output decode_pkg::result_src_t             result_src
);
    import decode_pkg::*;

    logic [4:0] funct5;
    logic       single_fmt;
    logic       rm_ok;

    assign funct5 = funct7[6:2];
    // only single precision, fmt field 00.
    assign single_fmt = (funct7[1:0] == 2'b00);
    // rounding modes 101 and 110 are reserved.
    assign rm_ok = (funct3 != 3'b101) && (funct3 != 3'b110);

    // integer alu operation for op and op-imm, alt selects sub/sra.
    function automatic alu_ctrl_t alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_op = alt ? alu_sub : alu_add;
            3'b001:  alu_op = alu_sll;
            3'b010:  alu_op = alu_slt;
            3'b011:  alu_op = alu_sltu;
            3'b100:  alu_op = alu_xor;
            3'b101:  alu_op = alt ? alu_sra : alu_srl;
            3'b110:  alu_op = alu_or;
            default: alu_op = alu_and;
        endcase
    endfunction

    always_comb begin
        reg_write     = 1'b0;
        fpu_reg_write = 1'b0;
        mem_write     = 1'b0;
        mem_read      = 1'b0;
        branch        = 1'b0;
        jump          = 1'b0;
        alu_src       = 1'b0;
        fp_mem        = 1'b0;
        csr_write     = 1'b0;
        illegal       = 1'b0;
        alu_ctrl      = alu_add;
        fpu_ctrl      = none;
        imm_src       = imm_none;
        result_src    = res_alu;

        case (opcode)
            op_lui: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = imm_u;
                alu_ctrl  = alu_lui_pass;
            end
            op_auipc: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = imm_u;
            end
            op_jal: begin
                reg_write  = 1'b1;
                jump       = 1'b1;
                imm_src    = imm_j;
                result_src = res_pc4;
            end
            op_jalr: begin
                reg_write  = 1'b1;
                jump       = 1'b1;
                alu_src    = 1'b1;
                imm_src    = imm_i;
                result_src = res_pc4;
                illegal    = (funct3 != 3'b000);
            end
            op_branch: begin
                branch  = 1'b1;
                imm_src = imm_b;
                case (funct3[2:1])
                    2'b00:   alu_ctrl = alu_sub;
                    2'b10:   alu_ctrl = alu_slt;
                    2'b11:   alu_ctrl = alu_sltu;
                    default: illegal  = 1'b1;
                endcase
            end
            op_load: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                alu_src    = 1'b1;
                imm_src    = imm_i;
                result_src = res_mem;
                illegal    = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = imm_s;
                illegal   = (funct3[2] == 1'b1) || (funct3 == 3'b011);
            end
            op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
                imm_src   = imm_i;
                // only srai uses the alternate encoding here.
                alu_ctrl  = alu_op(funct3, funct3 == 3'b101 && funct7 == 7'b0100000);
                if (funct3 == 3'b001)
                    illegal = (funct7 != 7'b0000000);
                else if (funct3 == 3'b101)
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
            op_reg: begin
                reg_write = 1'b1;
                case (funct7)
                    7'b0000000: alu_ctrl = alu_op(funct3, 1'b0);
                    7'b0100000: begin
                        alu_ctrl = alu_op(funct3, 1'b1);
                        illegal  = (funct3 != 3'b000) && (funct3 != 3'b101);
                    end
                    7'b0000001: begin
                        alu_ctrl = alu_mul;
                        illegal  = (funct3 != 3'b000);
                    end
                    default: illegal = 1'b1;
                endcase
            end
            op_system: begin
                imm_src = imm_i;
                if (funct3 == 3'b100) begin
                    illegal = 1'b1;
                end else if (funct3 != 3'b000) begin
                    csr_write = 1'b1;
                    reg_write = 1'b1;
                end
            end
            op_load_fp: begin
                fpu_reg_write = 1'b1;
                mem_read      = 1'b1;
                fp_mem        = 1'b1;
                alu_src       = 1'b1;
                imm_src       = imm_i;
                result_src    = res_mem;
                illegal       = (funct3 != 3'b010);
            end
            op_store_fp: begin
                mem_write = 1'b1;
                fp_mem    = 1'b1;
                alu_src   = 1'b1;
                imm_src   = imm_s;
                illegal   = (funct3 != 3'b010);
            end
            op_fp: begin
                result_src    = res_fpu;
                fpu_reg_write = 1'b1;
                case (funct5)
                    5'b00000: begin
                        fpu_ctrl = fadd;
                        illegal  = !rm_ok;
                    end
                    5'b00001: begin
                        fpu_ctrl = fsub;
                        illegal  = !rm_ok;
                    end
                    5'b00010: begin
                        fpu_ctrl = fmul;
                        illegal  = !rm_ok;
                    end
                    5'b00011: begin
                        fpu_ctrl = fdiv;
                        illegal  = !rm_ok;
                    end
                    5'b01011: begin
                        fpu_ctrl = fsqrt;
                        illegal  = !rm_ok || (rs2 != '0);
                    end
                    5'b00100: begin
                        fpu_ctrl = fsgnj;
                        illegal  = (funct3 > 3'b010);
                    end
                    5'b00101: begin
                        fpu_ctrl = fminmax;
                        illegal  = (funct3 > 3'b001);
                    end
                    5'b11010: begin
                        fpu_ctrl = fcvt_s;
                        illegal  = !rm_ok || (rs2 > 5'd1);
                    end
                    5'b11110: begin
                        fpu_ctrl = fmv_w;
                        illegal  = (funct3 != 3'b000) || (rs2 != '0);
                    end
                    // the rest write the integer bank.
                    5'b11000: begin
                        fpu_ctrl      = fcvt_w;
                        fpu_reg_write = 1'b0;
                        reg_write     = 1'b1;
                        illegal       = !rm_ok || (rs2 > 5'd1);
                    end
                    5'b10100: begin
                        fpu_ctrl      = fcmp;
                        fpu_reg_write = 1'b0;
                        reg_write     = 1'b1;
                        illegal       = (funct3 > 3'b010);
                    end
                    5'b11100: begin
                        fpu_ctrl      = (funct3 == 3'b001) ? fclass : fmv_x;
                        fpu_reg_write = 1'b0;
                        reg_write     = 1'b1;
                        illegal       = (funct3 > 3'b001) || (rs2 != '0);
                    end
                    default: illegal = 1'b1;
                endcase
                if (!single_fmt)
                    illegal = 1'b1;
            end
            op_fmadd, op_fmsub, op_fnmsub, op_fnmadd: begin
                fpu_reg_write = 1'b1;
                result_src    = res_fpu;
                illegal       = !single_fmt || !rm_ok;
                case (opcode)
                    op_fmadd:  fpu_ctrl = fmadd;
                    op_fmsub:  fpu_ctrl = fmsub;
                    op_fnmsub: fpu_ctrl = fnmsub;
                    default:   fpu_ctrl = fnmadd;
                endcase
            end
            default: illegal = 1'b1;
        endcase

        // an illegal instruction must not change any state.
        if (illegal) begin
            reg_write     = 1'b0;
            fpu_reg_write = 1'b0;
            mem_write     = 1'b0;
            mem_read      = 1'b0;
            branch        = 1'b0;
            jump          = 1'b0;
            csr_write     = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/reg_bank.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_bank #(
    parameter int read_ports = 2,
    parameter int zero_reg   = 1
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic                                              we,
    input  logic [decode_pkg::reg_addr_w-1:0]                 waddr,
    input  logic [decode_pkg::xlen-1:0]                       wdata,
    input  logic [read_ports-1:0][decode_pkg::reg_addr_w-1:0] raddr,
    output logic [read_ports-1:0][decode_pkg::xlen-1:0]       rdata
);
    import decode_pkg::*;

    localparam int depth = 1 << reg_addr_w;

    logic [xlen-1:0] mem [depth];
    logic            waddr_zero;
    logic            write_en;

    assign waddr_zero = (zero_reg != 0) && (waddr == '0);
    // a write to the hard-zero entry is dropped.
    assign write_en = we && !rst && !waddr_zero;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (write_en) begin
            mem[waddr] <= wdata;
        end
    end

    // reads are combinational, with write-through for the pending write.
    always_comb begin
        for (int p = 0; p < read_ports; p++) begin
            if (rst) begin
                rdata[p] = '0;
            end else if ((zero_reg != 0) && (raddr[p] == '0)) begin
                rdata[p] = '0;
            end else if (write_en && (raddr[p] == waddr)) begin
                rdata[p] = wdata;
            end else begin
                rdata[p] = mem[raddr[p]];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/imm_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
    input  logic [decode_pkg::xlen-1:0] instr,
    input  decode_pkg::imm_src_t        imm_src,
    output logic [decode_pkg::xlen-1:0] imm
);
    import decode_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            imm_i: begin
                imm = {{(xlen-12){sign}}, instr[31:20]};
            end
            imm_s: begin
                imm = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            end
            // branch offsets are in half-words, bit 0 is always zero.
            imm_b: begin
                imm = {{(xlen-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            imm_u: begin
                imm = {instr[31:12], 12'b0};
            end
            imm_j: begin
                imm = {{(xlen-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [decode_pkg::xlen-1:0]         instr,
    input  logic [decode_pkg::xlen-1:0]         pc,
    input  logic [decode_pkg::xlen-1:0]         pc_plus4,
    // from write back
    input  logic [decode_pkg::reg_addr_w-1:0]   rd_w,
    input  logic [decode_pkg::xlen-1:0]         result_w,
    input  logic                                reg_write_w,
    input  logic                                fpu_reg_write_w,
    // control word
    output logic                                reg_write,
    output logic                                fpu_reg_write,
    output logic                                mem_write,
    output logic                                mem_read,
    output logic                                branch,
    output logic                                jump,
    output logic                                alu_src,
    output logic                                fp_mem,
    output logic                                csr_write,
    output logic                                illegal,
    output decode_pkg::alu_ctrl_t               alu_ctrl,
    output decode_pkg::fpu_ctrl_t               fpu_ctrl,
    output decode_pkg::imm_src_t                imm_src,
    output decode_pkg::result_src_t             result_src,
    // data
    output logic [decode_pkg::xlen-1:0]         imm,
    output logic [decode_pkg::xlen-1:0]         rd1,
    output logic [decode_pkg::xlen-1:0]         rd2,
    output logic [decode_pkg::xlen-1:0]         fpu_rd1,
    output logic [decode_pkg::xlen-1:0]         fpu_rd2,
    output logic [decode_pkg::xlen-1:0]         fpu_rd3,
    output logic [decode_pkg::reg_addr_w-1:0]   rs1,
    output logic [decode_pkg::reg_addr_w-1:0]   rs2,
    output logic [decode_pkg::reg_addr_w-1:0]   rs3,
    output logic [decode_pkg::reg_addr_w-1:0]   rd,
    output logic [2:0]                          rm,
    output logic [4:0]                          funct5,
    output logic [decode_pkg::xlen-1:0]         pc_out,
    output logic [decode_pkg::xlen-1:0]         pc_plus4_out,
    output logic [decode_pkg::xlen-1:0]         instr_out
);
    import decode_pkg::*;

    opcode_t opcode;

    assign opcode = opcode_t'(instr[6:0]);

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    // third source of the r4 fused ops, shares bits with funct5.
    assign rs3 = instr[31:27];
    assign rd = instr[11:7];
    assign rm = instr[14:12];
    assign funct5 = instr[31:27];

    assign pc_out = pc;
    assign pc_plus4_out = pc_plus4;
    assign instr_out = instr;

    control_unit control_unit_inst (
        .opcode        (opcode),
        .funct3        (instr[14:12]),
        .funct7        (instr[31:25]),
        .rs2           (rs2),
        .reg_write     (reg_write),
        .fpu_reg_write (fpu_reg_write),
        .mem_write     (mem_write),
        .mem_read      (mem_read),
        .branch        (branch),
        .jump          (jump),
        .alu_src       (alu_src),
        .fp_mem        (fp_mem),
        .csr_write     (csr_write),
        .illegal       (illegal),
        .alu_ctrl      (alu_ctrl),
        .fpu_ctrl      (fpu_ctrl),
        .imm_src       (imm_src),
        .result_src    (result_src)
    );

    reg_bank #(
        .read_ports (2),
        .zero_reg   (1)
    ) int_bank (
        .clk   (clk),
        .rst   (rst),
        .we    (reg_write_w),
        .waddr (rd_w),
        .wdata (result_w),
        .raddr ({rs2, rs1}),
        .rdata ({rd2, rd1})
    );

    // f0 is an ordinary register.
    reg_bank #(
        .read_ports (3),
        .zero_reg   (0)
    ) fpu_bank (
        .clk   (clk),
        .rst   (rst),
        .we    (fpu_reg_write_w),
        .waddr (rd_w),
        .wdata (result_w),
        .raddr ({rs3, rs2, rs1}),
        .rdata ({fpu_rd3, fpu_rd2, fpu_rd1})
    );

    imm_gen imm_gen_inst (
        .instr   (instr),
        .imm_src (imm_src),
        .imm     (imm)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// name, instr, pc, rd_w, result_w, {reg_write_w, fpu_reg_write_w},
// flags {rw, frw, mem_wr, mem_rd, branch, jump, alu_src, fp_mem, csr, illegal},
// alu, fpu, imm_src, result_src, imm.
task automatic load_vectors();
    add_vector("lui_max", 32'hffff_f2b7, 32'h0000_0100, 5'd5, 32'h1234_5678, 2'b10,
               10'b1000001000, alu_lui_pass, none, imm_u, res_alu, 32'hffff_f000);
    add_vector("jal_neg", 32'hffff_f0ef, 32'h0000_0104, 5'd0, 32'h0000_0000, 2'b00,
               10'b1000010000, alu_add, none, imm_j, res_pc4, 32'hffff_fffe);
    add_vector("jalr_x5", 32'h00c2_8067, 32'h0000_0108, 5'd0, 32'h0000_0000, 2'b00,
               10'b1000011000, alu_add, none, imm_i, res_pc4, 32'h0000_000c);
    add_vector("beq_min", 32'h8062_8063, 32'h0000_010c, 5'd6, 32'hdead_beef, 2'b10,
               10'b0000100000, alu_sub, none, imm_b, res_alu, 32'hffff_f000);
    add_vector("lw_neg", 32'hfff0_2383, 32'h0000_0110, 5'd0, 32'hffff_ffff, 2'b10,
               10'b1001001000, alu_add, none, imm_i, res_mem, 32'hffff_ffff);
    add_vector("sw_max", 32'h7e50_2fa3, 32'h0000_0114, 5'd5, 32'h5555_aaaa, 2'b00,
               10'b0010001000, alu_add, none, imm_s, res_alu, 32'h0000_07ff);
    add_vector("sub", 32'h4062_8433, 32'h0000_0118, 5'd0, 32'h0000_0000, 2'b00,
               10'b1000000000, alu_sub, none, imm_none, res_alu, 32'h0000_0000);
    add_vector("mul", 32'h0262_84b3, 32'h0000_011c, 5'd0, 32'h3f80_0000, 2'b01,
               10'b1000000000, alu_mul, none, imm_none, res_alu, 32'h0000_0000);
    add_vector("flw", 32'h0082_a087, 32'h0000_0120, 5'd0, 32'h0000_0000, 2'b00,
               10'b0101001100, alu_add, none, imm_i, res_mem, 32'h0000_0008);
    add_vector("fadd", 32'h0010_0153, 32'h0000_0124, 5'd1, 32'h4000_0000, 2'b01,
               10'b0100000000, alu_add, fadd, imm_none, res_fpu, 32'h0000_0000);
    add_vector("fle", 32'ha010_0553, 32'h0000_0128, 5'd0, 32'h0000_0000, 2'b00,
               10'b1000000000, alu_add, fcmp, imm_none, res_fpu, 32'h0000_0000);
    add_vector("fmadd", 32'h2020_81c3, 32'h0000_012c, 5'd4, 32'hc0a0_0000, 2'b01,
               10'b0100000000, alu_add, fmadd, imm_none, res_fpu, 32'h0000_0000);
    add_vector("csrrw", 32'h3002_9673, 32'h0000_0130, 5'd0, 32'h0000_0000, 2'b00,
               10'b1000000010, alu_add, none, imm_i, res_alu, 32'h0000_0300);
    add_vector("bad_op", 32'h0000_007f, 32'h0000_0134, 5'd0, 32'h0000_0000, 2'b00,
               10'b0000000001, alu_add, none, imm_none, res_alu, 32'h0000_0000);
    add_vector("ld_illegal", 32'h0040_b103, 32'h0000_0138, 5'd0, 32'h0000_0000, 2'b00,
               10'b0000001001, alu_add, none, imm_i, res_mem, 32'h0000_0004);
endtask

`endif

// ==== testbench/tb_instr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_instr_decode;
    import decode_pkg::*;

    localparam int num_vectors = 15;
    localparam int reset_cycles = 10;
    localparam int sweep_cycles = 16;
    localparam int random_cycles = 200;
    localparam int cycle_limit = reset_cycles + sweep_cycles + num_vectors + random_cycles + 20;
    localparam logic [31:0] lfsr_seed = 32'h38fe_4bc2;
    localparam logic [31:0] nop_instr = 32'h0000_0013;

    logic                  clk;
    logic                  rst;
    logic [xlen-1:0]       instr;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       pc_plus4;
    logic [reg_addr_w-1:0] rd_w;
    logic [xlen-1:0]       result_w;
    logic                  reg_write_w;
    logic                  fpu_reg_write_w;
    logic                  reg_write;
    logic                  fpu_reg_write;
    logic                  mem_write;
    logic                  mem_read;
    logic                  branch;
    logic                  jump;
    logic                  alu_src;
    logic                  fp_mem;
    logic                  csr_write;
    logic                  illegal;
    alu_ctrl_t             alu_ctrl;
    fpu_ctrl_t             fpu_ctrl;
    imm_src_t              imm_src;
    result_src_t           result_src;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;
    logic [xlen-1:0]       fpu_rd1;
    logic [xlen-1:0]       fpu_rd2;
    logic [xlen-1:0]       fpu_rd3;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs3;
    logic [reg_addr_w-1:0] rd;
    logic [2:0]            rm;
    logic [4:0]            funct5;
    logic [xlen-1:0]       pc_out;
    logic [xlen-1:0]       pc_plus4_out;
    logic [xlen-1:0]       instr_out;

    // shadow copies of both banks.
    logic [xlen-1:0] int_regs [32];
    logic [xlen-1:0] fp_regs [32];
    logic [31:0]     lfsr_state;
    int              cycle_count = 0;
    int              vec_count = 0;

    string           vec_name [num_vectors];
    logic [31:0]     vec_instr [num_vectors];
    logic [31:0]     vec_pc [num_vectors];
    logic [4:0]      vec_rd_w [num_vectors];
    logic [31:0]     vec_result [num_vectors];
    logic [1:0]      vec_we [num_vectors];
    logic [9:0]      vec_flags [num_vectors];
    alu_ctrl_t       vec_alu [num_vectors];
    fpu_ctrl_t       vec_fpu [num_vectors];
    imm_src_t        vec_imm_src [num_vectors];
    result_src_t     vec_res [num_vectors];
    logic [31:0]     vec_imm [num_vectors];

    instr_decode instr_decode_inst (.*);

    `include "tb_vectors.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d clock cycles", cycle_limit);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input string what,
                              input logic [xlen-1:0] exp_val, input logic [xlen-1:0] act_val);
        if (act_val !== exp_val)
            report_failure($sformatf("CHECK FAILED %s %s expected %h actual %h",
                                     name, what, exp_val, act_val));
    endtask

    task automatic check_idx(input string name, input string what,
                             input logic [reg_addr_w-1:0] exp_val,
                             input logic [reg_addr_w-1:0] act_val);
        if (act_val !== exp_val)
            report_failure($sformatf("CHECK FAILED %s %s expected %0d actual %0d",
                                     name, what, exp_val, act_val));
    endtask

    task automatic check_ctrl(input string name,
                              input logic [9:0] exp_flags, input logic [9:0] act_flags,
                              input alu_ctrl_t exp_alu, input alu_ctrl_t act_alu,
                              input fpu_ctrl_t exp_fpu, input fpu_ctrl_t act_fpu,
                              input imm_src_t exp_imm, input imm_src_t act_imm,
                              input result_src_t exp_res, input result_src_t act_res);
        if (act_flags !== exp_flags)
            report_failure($sformatf("CHECK FAILED %s flags expected %b actual %b",
                                     name, exp_flags, act_flags));
        if (act_alu !== exp_alu)
            report_failure($sformatf("CHECK FAILED %s alu_ctrl expected %0d actual %0d",
                                     name, exp_alu, act_alu));
        if (act_fpu !== exp_fpu)
            report_failure($sformatf("CHECK FAILED %s fpu_ctrl expected %0d actual %0d",
                                     name, exp_fpu, act_fpu));
        if (act_imm !== exp_imm)
            report_failure($sformatf("CHECK FAILED %s imm_src expected %0d actual %0d",
                                     name, exp_imm, act_imm));
        if (act_res !== exp_res)
            report_failure($sformatf("CHECK FAILED %s result_src expected %0d actual %0d",
                                     name, exp_res, act_res));
    endtask

    task automatic add_vector(input string name, input logic [31:0] word,
                              input logic [31:0] addr, input logic [4:0] wb_rd,
                              input logic [31:0] wb_data, input logic [1:0] wb_en,
                              input logic [9:0] flags, input alu_ctrl_t alu_op,
                              input fpu_ctrl_t fpu_op, input imm_src_t imm_fmt,
                              input result_src_t res_sel, input logic [31:0] imm_val);
        if (vec_count >= num_vectors) begin
            report_failure("the vector table holds more entries than the testbench expects");
        end else begin
            vec_name[vec_count] = name;
            vec_instr[vec_count] = word;
            vec_pc[vec_count] = addr;
            vec_rd_w[vec_count] = wb_rd;
            vec_result[vec_count] = wb_data;
            vec_we[vec_count] = wb_en;
            vec_flags[vec_count] = flags;
            vec_alu[vec_count] = alu_op;
            vec_fpu[vec_count] = fpu_op;
            vec_imm_src[vec_count] = imm_fmt;
            vec_res[vec_count] = res_sel;
            vec_imm[vec_count] = imm_val;
            vec_count++;
        end
    endtask

    // drive on the falling edge, then settle 1 ns before the rising edge.
    task automatic apply_inputs(input logic [31:0] word, input logic [31:0] addr,
                                input logic [4:0] wb_rd, input logic [31:0] wb_data,
                                input logic wb_int, input logic wb_fp);
        @(negedge clk);
        instr = word;
        pc = addr;
        pc_plus4 = addr + 32'd4;
        rd_w = wb_rd;
        result_w = wb_data;
        reg_write_w = wb_int;
        fpu_reg_write_w = wb_fp;
        // pending writes are visible in the same cycle.
        if (wb_int && wb_rd != 5'd0)
            int_regs[wb_rd] = wb_data;
        if (wb_fp)
            fp_regs[wb_rd] = wb_data;
        #1;
    endtask

    task automatic check_reads(input string name);
        check_word(name, "rd1", int_regs[instr[19:15]], rd1);
        check_word(name, "rd2", int_regs[instr[24:20]], rd2);
        check_word(name, "fpu_rd1", fp_regs[instr[19:15]], fpu_rd1);
        check_word(name, "fpu_rd2", fp_regs[instr[24:20]], fpu_rd2);
        check_word(name, "fpu_rd3", fp_regs[instr[31:27]], fpu_rd3);
    endtask

    task automatic check_fields(input string name, input logic [31:0] exp_pc);
        check_idx(name, "rs1", instr[19:15], rs1);
        check_idx(name, "rs2", instr[24:20], rs2);
        check_idx(name, "rs3", instr[31:27], rs3);
        check_idx(name, "rd", instr[11:7], rd);
        check_word(name, "rm", {29'b0, instr[14:12]}, {29'b0, rm});
        check_word(name, "funct5", {27'b0, instr[31:27]}, {27'b0, funct5});
        check_word(name, "pc_out", exp_pc, pc_out);
        check_word(name, "pc_plus4_out", exp_pc + 32'd4, pc_plus4_out);
        check_word(name, "instr_out", instr, instr_out);
    endtask

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    initial begin
        logic [31:0] word;
        logic [4:0]  sweep_idx;
        logic [31:0] r_rs1;
        logic [31:0] r_rs2;
        logic [31:0] r_rs3;
        logic [31:0] r_rd;
        logic [31:0] r_data;
        logic [31:0] r_int;
        logic [31:0] r_fp;

        rst = 1'b1;
        instr = nop_instr;
        pc = '0;
        pc_plus4 = 32'd4;
        rd_w = '0;
        result_w = '0;
        reg_write_w = 1'b0;
        fpu_reg_write_w = 1'b0;
        lfsr_state = lfsr_seed;
        for (int i = 0; i < 32; i++) begin
            int_regs[i] = '0;
            fp_regs[i] = '0;
        end
        load_vectors();
        if (vec_count != num_vectors)
            report_failure("the vector table holds fewer entries than the testbench expects");

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // every entry of both banks reads zero after reset.
        sweep_idx = 5'd0;
        for (int k = 0; k < sweep_cycles; k++) begin
            word = {sweep_idx, 2'b00, sweep_idx + 5'd1, sweep_idx, 3'b000, 5'd0, 7'b1000011};
            apply_inputs(word, 32'h0, 5'd0, 32'h0, 1'b0, 1'b0);
            check_word("reset_sweep", "rd1", 32'h0, rd1);
            check_word("reset_sweep", "rd2", 32'h0, rd2);
            check_word("reset_sweep", "fpu_rd1", 32'h0, fpu_rd1);
            check_word("reset_sweep", "fpu_rd2", 32'h0, fpu_rd2);
            check_word("reset_sweep", "fpu_rd3", 32'h0, fpu_rd3);
            sweep_idx = sweep_idx + 5'd2;
        end

        for (int v = 0; v < num_vectors; v++) begin
            apply_inputs(vec_instr[v], vec_pc[v], vec_rd_w[v], vec_result[v],
                         vec_we[v][1], vec_we[v][0]);
            check_ctrl(vec_name[v], vec_flags[v],
                       {reg_write, fpu_reg_write, mem_write, mem_read, branch,
                        jump, alu_src, fp_mem, csr_write, illegal},
                       vec_alu[v], alu_ctrl, vec_fpu[v], fpu_ctrl,
                       vec_imm_src[v], imm_src, vec_res[v], result_src);
            check_word(vec_name[v], "imm", vec_imm[v], imm);
            check_fields(vec_name[v], vec_pc[v]);
            check_reads(vec_name[v]);
        end

        // random writes against r4-style reads of all five ports.
        for (int n = 0; n < random_cycles; n++) begin
            draw_bits(5, r_rs1);
            draw_bits(5, r_rs2);
            draw_bits(5, r_rs3);
            draw_bits(5, r_rd);
            draw_bits(32, r_data);
            draw_bits(1, r_int);
            draw_bits(1, r_fp);
            word = {r_rs3[4:0], 2'b00, r_rs2[4:0], r_rs1[4:0], 3'b000, 5'd0, 7'b1000011};
            apply_inputs(word, 32'h0000_0200, r_rd[4:0], r_data, r_int[0], r_fp[0]);
            check_reads($sformatf("random_%0d", n));
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+testbench
design/decode_pkg.sv
design/control_unit.sv
design/reg_bank.sv
design/imm_gen.sv
design/instr_decode.sv
testbench/tb_instr_decode.sv
